/* design/timer_pkg.sv */
package timer_pkg;

    localparam int num_ch  = 4;   // Timer channels in the subsystem
    localparam int count_w = 32;  // Counter, reload and compare width
    localparam int presc_w = 16;  // Prescaler width

    // Channel operating mode, same encoding as the single-channel timer
    typedef enum logic [1:0] {
        mode_off      = 2'b00,
        mode_one_shot = 2'b01,
        mode_periodic = 2'b10,
        mode_pwm      = 2'b11
    } timer_mode_e;

    // Register select on the host write port
    typedef enum logic [1:0] {
        reg_ctrl    = 2'b00,  // Start, mode and prescaler
        reg_reload  = 2'b01,  // Reload value, raw word
        reg_compare = 2'b10   // PWM compare value, raw word
    } reg_sel_e;

    // Control view of a write word, MSB first
    typedef struct packed {
        logic               start;
        timer_mode_e        mode;
        logic [12:0]        rsvd;   // Ignored on write
        logic [presc_w-1:0] presc;
    } cfg_ctrl_t;

    // Write data is read as control fields or as one raw value
    typedef union packed {
        cfg_ctrl_t          ctrl;
        logic [count_w-1:0] raw;
    } cfg_word_u;

endpackage

/* design/evt_pkg.sv */
package evt_pkg;

    localparam int ch_idx_w = 2;  // Channel index on the event bus
    localparam int seq_w    = 8;  // Per-channel event sequence number

    // What caused the counter event
    typedef enum logic {
        evt_expire = 1'b0,  // One-shot reached zero
        evt_wrap   = 1'b1   // Periodic reload
    } evt_kind_e;

endpackage

/* design/timer_regs.sv */
`timescale 1ns/1ps

module timer_regs (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_valid,
    output logic                          cfg_ready,
    input  logic [evt_pkg::ch_idx_w-1:0]  cfg_ch,
    input  timer_pkg::reg_sel_e           cfg_sel,
    input  timer_pkg::cfg_word_u          cfg_data,
    output timer_pkg::timer_mode_e        mode        [timer_pkg::num_ch],
    output logic [timer_pkg::presc_w-1:0] prescaler   [timer_pkg::num_ch],
    output logic [timer_pkg::count_w-1:0] reload_val  [timer_pkg::num_ch],
    output logic [timer_pkg::count_w-1:0] compare_val [timer_pkg::num_ch],
    output logic [timer_pkg::num_ch-1:0]  start
);

    import timer_pkg::*;

    logic wr_en;  // Accepted host write this cycle

    assign wr_en = cfg_valid && cfg_ready;

    // Ready comes up one edge after reset is released
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_ready <= 1'b0;
        end else begin
            cfg_ready <= 1'b1;
        end
    end

    // Configuration registers for all channels
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start <= '0;
            for (int i = 0; i < num_ch; i++) begin
                mode[i]        <= mode_off;   // Channels come up stopped
                prescaler[i]   <= '0;
                reload_val[i]  <= '0;
                compare_val[i] <= '0;
            end
        end else begin
            start <= '0;                      // Start is a single-cycle pulse
            if (wr_en) begin
                case (cfg_sel)
                    reg_ctrl: begin
                        // Mode and prescaler change together
                        mode[cfg_ch]      <= cfg_data.ctrl.mode;
                        prescaler[cfg_ch] <= cfg_data.ctrl.presc;
                        start[cfg_ch]     <= cfg_data.ctrl.start;
                    end
                    reg_reload:  reload_val[cfg_ch]  <= cfg_data.raw;
                    reg_compare: compare_val[cfg_ch] <= cfg_data.raw;
                    default: ;                // Unmapped select, write is dropped
                endcase
            end
        end
    end

endmodule

/* design/multi_mode_timer.sv */
`timescale 1ns/1ps

module multi_mode_timer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  timer_pkg::timer_mode_e        mode,
    input  logic [timer_pkg::presc_w-1:0] prescaler,
    input  logic [timer_pkg::count_w-1:0] reload_val,
    input  logic [timer_pkg::count_w-1:0] compare_val,
    input  logic                          start,
    output logic                          pwm_out,
    output logic [timer_pkg::count_w-1:0] current_count,
    output logic                          ev_valid,
    input  logic                          ev_ready,
    output evt_pkg::evt_kind_e            ev_kind,
    output logic [evt_pkg::seq_w-1:0]     ev_seq,
    output logic                          ev_lost
);

    import timer_pkg::*;
    import evt_pkg::*;

    typedef enum logic {st_idle = 1'b0, st_run = 1'b1} state_e;

    state_e             state;
    state_e             state_nxt;
    logic [presc_w-1:0] presc_cnt;   // Cycles since last counter step
    logic               step;        // Counter may advance this cycle
    logic               at_zero;
    logic               load_cnt;    // Load reload value into counter
    logic               post_evt;    // New event for the holder
    evt_kind_e          post_kind;
    logic [seq_w-1:0]   seq_cnt;     // Next sequence number to hand out
    logic               drain;       // Pending event taken by the arbiter

    assign at_zero = (current_count == '0);
    assign step    = (state == st_run) && (presc_cnt >= prescaler);  // Every p+1 cycles
    assign drain   = ev_valid && ev_ready;

    // Prescaler restarts whenever the channel is idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            presc_cnt <= '0;
        end else if ((state != st_run) || step) begin
            presc_cnt <= '0;
        end else begin
            presc_cnt <= presc_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Next state, counter load and event posting
    always_comb begin
        state_nxt = state;
        load_cnt  = 1'b0;
        post_evt  = 1'b0;
        post_kind = evt_wrap;
        case (state)
            st_idle: begin
                if (start && (mode != mode_off)) begin
                    state_nxt = st_run;
                    load_cnt  = 1'b1;          // First load on the start cycle
                end
            end
            st_run: begin
                if (mode == mode_off) begin
                    state_nxt = st_idle;       // Stop at once
                end else if (at_zero && (mode == mode_one_shot)) begin
                    state_nxt = st_idle;
                    post_evt  = 1'b1;
                    post_kind = evt_expire;
                end else if (at_zero && step) begin
                    // Zero counts as one step, so the period is R+1 steps
                    load_cnt = 1'b1;
                    post_evt = (mode == mode_periodic);  // PWM reloads silently
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    // Down counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            current_count <= '0;
        end else if (load_cnt) begin
            current_count <= reload_val;
        end else if (step && !at_zero) begin
            current_count <= current_count - 1'b1;
        end
    end

    // One-entry holder, an overrun marks the pending event as lost
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ev_valid <= 1'b0;
            ev_lost  <= 1'b0;
            seq_cnt  <= '0;
        end else if (post_evt) begin
            ev_valid <= 1'b1;
            ev_lost  <= ev_valid && !drain;  // Previous one still waiting
            seq_cnt  <= seq_cnt + 1'b1;
        end else if (drain) begin
            ev_valid <= 1'b0;
            ev_lost  <= 1'b0;
        end
    end

    // Event payload, newest event overwrites
    always_ff @(posedge clk) begin
        if (post_evt) begin
            ev_kind <= post_kind;
            ev_seq  <= seq_cnt;
        end
    end

    // High while count is above compare, only when running in PWM mode
    always_comb begin
        pwm_out = 1'b0;
        if ((mode == mode_pwm) && (state == st_run)) begin
            pwm_out = (current_count > compare_val);
        end
    end

endmodule

/* design/event_arbiter.sv */
`timescale 1ns/1ps

module event_arbiter (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [timer_pkg::num_ch-1:0]     ev_valid,
    output logic [timer_pkg::num_ch-1:0]     ev_ready,
    input  evt_pkg::evt_kind_e               ev_kind [timer_pkg::num_ch],
    input  logic [evt_pkg::seq_w-1:0]        ev_seq  [timer_pkg::num_ch],
    input  logic [timer_pkg::num_ch-1:0]     ev_lost,
    output logic                             evt_valid,
    input  logic                             evt_ready,
    output logic [evt_pkg::ch_idx_w-1:0]     evt_ch,
    output evt_pkg::evt_kind_e               evt_kind,
    output logic [evt_pkg::seq_w-1:0]        evt_seq,
    output logic                             evt_lost
);

    import timer_pkg::*;
    import evt_pkg::*;

    logic [ch_idx_w-1:0] rr_ptr;     // First channel to look at
    logic [ch_idx_w-1:0] gnt_idx;
    logic                gnt_found;
    logic                load_en;    // Output register free or draining

    assign load_en = !evt_valid || evt_ready;

    // Search requests starting at the pointer, wrapping around
    always_comb begin
        logic [ch_idx_w-1:0] cand;
        gnt_found = 1'b0;
        gnt_idx   = rr_ptr;
        for (int i = 0; i < num_ch; i++) begin
            cand = rr_ptr + ch_idx_w'(i);
            if (!gnt_found && ev_valid[cand]) begin
                gnt_found = 1'b1;
                gnt_idx   = cand;
            end
        end
    end

    // Grant goes back to exactly one channel
    always_comb begin
        ev_ready = '0;
        if (load_en && gnt_found) begin
            ev_ready[gnt_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            evt_valid <= 1'b0;
            rr_ptr    <= '0;
        end else if (load_en) begin
            evt_valid <= gnt_found;
            if (gnt_found) begin
                rr_ptr <= gnt_idx + ch_idx_w'(1);  // Winner goes to the back
            end
        end
    end

    // Output fields, held while the consumer stalls
    always_ff @(posedge clk) begin
        if (load_en && gnt_found) begin
            evt_ch   <= gnt_idx;
            evt_kind <= ev_kind[gnt_idx];
            evt_seq  <= ev_seq[gnt_idx];
            evt_lost <= ev_lost[gnt_idx];
        end
    end

endmodule

/* design/timer_subsystem.sv */
`timescale 1ns/1ps

module timer_subsystem (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          cfg_valid,
    output logic                          cfg_ready,
    input  logic [evt_pkg::ch_idx_w-1:0]  cfg_ch,
    input  timer_pkg::reg_sel_e           cfg_sel,
    input  timer_pkg::cfg_word_u          cfg_data,
    output logic                          evt_valid,
    input  logic                          evt_ready,
    output logic [evt_pkg::ch_idx_w-1:0]  evt_ch,
    output evt_pkg::evt_kind_e            evt_kind,
    output logic [evt_pkg::seq_w-1:0]     evt_seq,
    output logic                          evt_lost,
    output logic [timer_pkg::num_ch-1:0]  pwm_out
);

    import timer_pkg::*;
    import evt_pkg::*;

    // Register block to channels
    timer_mode_e        ch_mode    [num_ch];
    logic [presc_w-1:0] ch_presc   [num_ch];
    logic [count_w-1:0] ch_reload  [num_ch];
    logic [count_w-1:0] ch_compare [num_ch];
    logic [num_ch-1:0]  ch_start;

    // Channels to arbiter
    logic [num_ch-1:0]  ev_valid;
    logic [num_ch-1:0]  ev_ready;
    evt_kind_e          ev_kind    [num_ch];
    logic [seq_w-1:0]   ev_seq     [num_ch];
    logic [num_ch-1:0]  ev_lost;

    timer_regs timer_regs_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .cfg_ch      (cfg_ch),
        .cfg_sel     (cfg_sel),
        .cfg_data    (cfg_data),
        .mode        (ch_mode),
        .prescaler   (ch_presc),
        .reload_val  (ch_reload),
        .compare_val (ch_compare),
        .start       (ch_start)
    );

    for (genvar g = 0; g < num_ch; g++) begin : gen_ch
        multi_mode_timer timer_i (
            .clk           (clk),
            .rst_n         (rst_n),
            .mode          (ch_mode[g]),
            .prescaler     (ch_presc[g]),
            .reload_val    (ch_reload[g]),
            .compare_val   (ch_compare[g]),
            .start         (ch_start[g]),
            .pwm_out       (pwm_out[g]),
            .current_count (),               // Count is internal only
            .ev_valid      (ev_valid[g]),
            .ev_ready      (ev_ready[g]),
            .ev_kind       (ev_kind[g]),
            .ev_seq        (ev_seq[g]),
            .ev_lost       (ev_lost[g])
        );
    end

    event_arbiter event_arbiter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .ev_valid  (ev_valid),
        .ev_ready  (ev_ready),
        .ev_kind   (ev_kind),
        .ev_seq    (ev_seq),
        .ev_lost   (ev_lost),
        .evt_valid (evt_valid),
        .evt_ready (evt_ready),
        .evt_ch    (evt_ch),
        .evt_kind  (evt_kind),
        .evt_seq   (evt_seq),
        .evt_lost  (evt_lost)
    );

endmodule

/* bench/timer_assert.sv */
`timescale 1ns/1ps

module timer_assert (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         evt_valid,
    input logic                         evt_ready,
    input logic [evt_pkg::ch_idx_w-1:0] evt_ch,
    input evt_pkg::evt_kind_e           evt_kind,
    input logic [evt_pkg::seq_w-1:0]    evt_seq,
    input logic                         evt_lost,
    input logic [timer_pkg::num_ch-1:0] ev_ready
);

    int fail_cnt = 0;  // Failed assertions so far

    // Output register is empty while reset is held
    evt_low_in_reset: assert property (@(posedge clk) !rst_n |-> !evt_valid)
        else begin
            fail_cnt++;
            $error("evt_valid high during reset");
        end

    // A stalled event keeps every field until the consumer takes it
    evt_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (evt_valid && !evt_ready) |=>
        (evt_valid && $stable({evt_ch, evt_kind, evt_seq, evt_lost})))
        else begin
            fail_cnt++;
            $error("Event output changed while evt_ready was low");
        end

    grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(ev_ready))
        else begin
            fail_cnt++;
            $error("More than one channel granted in one cycle");
        end

endmodule

bind event_arbiter timer_assert timer_assert_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .evt_valid (evt_valid),
    .evt_ready (evt_ready),
    .evt_ch    (evt_ch),
    .evt_kind  (evt_kind),
    .evt_seq   (evt_seq),
    .evt_lost  (evt_lost),
    .ev_ready  (ev_ready)
);

/* bench/timer_checker.sv */
`timescale 1ns/1ps

module timer_checker (
    input logic                         clk,
    input logic                         evt_valid,
    input logic                         evt_ready,
    input logic [evt_pkg::ch_idx_w-1:0] evt_ch,
    input evt_pkg::evt_kind_e           evt_kind,
    input logic [evt_pkg::seq_w-1:0]    evt_seq,
    input logic                         evt_lost,
    input logic [timer_pkg::num_ch-1:0] pwm_out
);

    import timer_pkg::*;
    import evt_pkg::*;

    int                errors = 0;
    int                phase  = 0;     // 0 idle, 1 test running, 2 quiet window
    int                cycle  = 0;
    string             name   = "none";
    logic [num_ch-1:0] mask;
    timer_mode_e       mode;
    bit                bp;
    int                t0;             // Cycle the test window opened
    int                run_len;
    int                period;         // Cycles per counter period
    int                hi_len;
    int                lo_len;
    int                n_expect;       // Events each active channel must post
    int                last_ch;
    bit                lost_seen;
    bit                held;
    logic [12:0]       held_word;      // Valid and fields of a stalled event
    logic [12:0]       now_word;
    logic [seq_w-1:0]  exp_seq   [num_ch] = '{default: '0};
    int                posted    [num_ch];  // Delivered plus overrun
    int                last_t    [num_ch];
    int                lvl_len   [num_ch];
    logic              lvl       [num_ch];
    bit                edge_seen [num_ch];
    int                hi_runs   [num_ch];

    assign now_word = {evt_valid, evt_ch, evt_kind, evt_seq, evt_lost};

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("Mismatch %s: %s expected %0d actual %0d", name, what, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("Error in %s: %s", name, msg);
        errors++;
    endtask

    task automatic begin_test(input string t_name, input logic [num_ch-1:0] t_mask,
                              input timer_mode_e t_mode, input int t_presc, input int t_reload,
                              input int t_compare, input int t_run, input bit t_bp);
        name      = t_name;
        mask      = t_mask;
        mode      = t_mode;
        bp        = t_bp;
        t0        = cycle;
        run_len   = t_run;
        period    = (t_reload + 1) * (t_presc + 1);       // R+1 steps of p+1 cycles
        hi_len    = (t_reload - t_compare) * (t_presc + 1);
        lo_len    = (t_compare + 1) * (t_presc + 1);
        lost_seen = 1'b0;
        last_ch   = -1;
        case (t_mode)
            mode_one_shot: n_expect = 1;
            mode_periodic: n_expect = (t_run + $countones(t_mask) - 1) / period;  // Stagger
            default:       n_expect = 0;
        endcase
        for (int ch = 0; ch < num_ch; ch++) begin
            posted[ch]    = 0;
            last_t[ch]    = -1;
            lvl_len[ch]   = 0;
            lvl[ch]       = 1'b0;
            edge_seen[ch] = 1'b0;
            hi_runs[ch]   = 0;
        end
        phase = 1;
    endtask

    task automatic finish_test();
        for (int ch = 0; ch < num_ch; ch++) begin
            if (mask[ch]) begin
                if (posted[ch] != n_expect) begin
                    report_mismatch($sformatf("events posted by ch%0d", ch), n_expect,
                                    posted[ch]);
                end
                if (mode == mode_pwm && hi_runs[ch] == 0) begin
                    report_failure($sformatf("no whole PWM period seen on ch%0d", ch));
                end
            end
        end
        if (bp && !lost_seen) begin
            report_failure("no event with evt_lost came out after the long stall");
        end
        phase = 2;                     // Channels are off now
    endtask

    task automatic end_quiet();
        phase = 0;
    endtask

    task automatic check_event();
        logic [seq_w-1:0] gap;
        int               ch;
        int               exp_ch;
        evt_kind_e        exp_kind;
        ch       = int'(evt_ch);
        gap      = evt_seq - exp_seq[ch];   // Overwritten events in between
        exp_kind = (mode == mode_one_shot) ? evt_expire : evt_wrap;
        if (!mask[ch] || mode == mode_pwm) begin
            report_failure($sformatf("event from ch%0d, which should be silent", ch));
        end else if (evt_kind != exp_kind) begin
            report_mismatch("evt_kind", exp_kind, evt_kind);
        end
        if (evt_lost && gap == 0) begin
            report_mismatch("evt_seq after an overrun, at least", exp_seq[ch] + 1, evt_seq);
        end else if (!evt_lost && gap != 0) begin
            report_mismatch("evt_seq", exp_seq[ch], evt_seq);
        end
        lost_seen   = lost_seen || evt_lost;
        posted[ch]  = posted[ch] + 1 + gap;
        exp_seq[ch] = evt_seq + 1'b1;
        // Spacing only holds for a lone channel on a bus that never stalls
        if (!bp && $countones(mask) == 1 && mode == mode_periodic && last_t[ch] >= 0) begin
            if (cycle - last_t[ch] > period + 2 || cycle - last_t[ch] < period - 2) begin
                report_mismatch("event spacing", period, cycle - last_t[ch]);
            end
        end
        last_t[ch] = cycle;
        if (!bp && $countones(mask) > 1 && last_ch >= 0) begin
            exp_ch = (last_ch + 1) % num_ch;
            for (int i = 0; i < num_ch && !mask[exp_ch]; i++) begin
                exp_ch = (exp_ch + 1) % num_ch;   // Next running channel in turn
            end
            if (ch != exp_ch) begin
                report_mismatch("evt_ch in round-robin order", exp_ch, ch);
            end
        end
        last_ch = ch;
    endtask

    // Whole high and low runs only, the first and last run are cut short
    task automatic track_pwm(input int ch);
        if (pwm_out[ch] == lvl[ch]) begin
            lvl_len[ch]++;
        end else begin
            if (edge_seen[ch] && lvl[ch]) begin
                hi_runs[ch]++;
                if (lvl_len[ch] != hi_len) begin
                    report_mismatch("pwm high cycles", hi_len, lvl_len[ch]);
                end
            end else if (edge_seen[ch] && lvl_len[ch] != lo_len) begin
                report_mismatch("pwm low cycles", lo_len, lvl_len[ch]);
            end
            edge_seen[ch] = 1'b1;
            lvl[ch]       = pwm_out[ch];
            lvl_len[ch]   = 1;
        end
    endtask

    // Mid-cycle sampling, a transfer happens on the next rising edge
    always @(negedge clk) begin
        cycle++;
        if (phase == 1) begin
            if (held && now_word != held_word) begin
                report_mismatch("stalled event word", held_word, now_word);
            end
            held      = evt_valid && !evt_ready;
            held_word = now_word;
            if (evt_valid && evt_ready) begin
                check_event();
            end
            for (int ch = 0; ch < num_ch; ch++) begin
                if (mask[ch] && mode == mode_pwm && cycle - t0 < run_len) begin
                    track_pwm(ch);
                end
            end
        end else if (phase == 2) begin
            held = 1'b0;
            if (evt_valid) begin
                report_mismatch("evt_valid after mode off", 0, 1);
            end
            if (pwm_out != '0) begin
                report_mismatch("pwm_out after mode off", 0, pwm_out);
            end
        end
    end

endmodule

/* bench/tb_timer_subsystem.sv */
`timescale 1ns/1ps

module tb_timer_subsystem;

    import timer_pkg::*;
    import evt_pkg::*;

    // One stimulus row, the checker derives its expectations from the same fields
    typedef struct {
        string             name;
        logic [num_ch-1:0] mask;     // Channels started by the row
        timer_mode_e       mode;
        int                presc;
        int                reload;
        int                compare;
        int                run;      // Cycles from start to mode off
        bit                bp;       // Random stalls on evt_ready
    } row_t;

    row_t rows [8] = '{
        '{"one_shot_r5",   4'b0001, mode_one_shot, 0, 5, 0, 30,  1'b0},
        '{"one_shot_p1",   4'b0001, mode_one_shot, 1, 3, 0, 30,  1'b0},
        '{"periodic_r9",   4'b0010, mode_periodic, 0, 9, 0, 45,  1'b0},
        '{"periodic_p2",   4'b0100, mode_periodic, 2, 4, 0, 52,  1'b0},
        '{"pwm_r7_c2",     4'b1000, mode_pwm,      0, 7, 2, 40,  1'b0},
        '{"pwm_p1",        4'b0001, mode_pwm,      1, 5, 1, 50,  1'b0},
        '{"arbitrate_all", 4'b1111, mode_periodic, 0, 7, 0, 42,  1'b0},
        '{"back_pressure", 4'b0010, mode_periodic, 0, 3, 0, 122, 1'b1}
    };

    logic                clk;
    logic                rst_n;
    logic                cfg_valid;
    logic                cfg_ready;
    logic [ch_idx_w-1:0] cfg_ch;
    reg_sel_e            cfg_sel;
    cfg_word_u           cfg_data;
    logic                evt_valid;
    logic                evt_ready;
    logic [ch_idx_w-1:0] evt_ch;
    evt_kind_e           evt_kind;
    logic [seq_w-1:0]    evt_seq;
    logic                evt_lost;
    logic [num_ch-1:0]   pwm_out;
    int                  bench_errors = 0;  // Timeouts and reset checks
    bit                  timed_out    = 1'b0;

    always #5 clk = ~clk;  // 10 ns period

    timer_subsystem timer_subsystem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .cfg_ch    (cfg_ch),
        .cfg_sel   (cfg_sel),
        .cfg_data  (cfg_data),
        .evt_valid (evt_valid),
        .evt_ready (evt_ready),
        .evt_ch    (evt_ch),
        .evt_kind  (evt_kind),
        .evt_seq   (evt_seq),
        .evt_lost  (evt_lost),
        .pwm_out   (pwm_out)
    );

    timer_checker checker_i (
        .clk       (clk),
        .evt_valid (evt_valid),
        .evt_ready (evt_ready),
        .evt_ch    (evt_ch),
        .evt_kind  (evt_kind),
        .evt_seq   (evt_seq),
        .evt_lost  (evt_lost),
        .pwm_out   (pwm_out)
    );

    // Inputs always change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic timeout_fail(input string msg);
        $display("Timeout: %s", msg);
        bench_errors++;
        timed_out = 1'b1;
    endtask

    function automatic cfg_word_u ctrl_word(input bit start, input timer_mode_e mode,
                                            input int presc);
        cfg_word_u w;
        w.raw        = '0;           // Reserved bits stay zero
        w.ctrl.start = start;
        w.ctrl.mode  = mode;
        w.ctrl.presc = presc[presc_w-1:0];
        return w;
    endfunction

    function automatic cfg_word_u raw_word(input int value);
        cfg_word_u w;
        w.raw = value;
        return w;
    endfunction

    // One host write, held until the DUT takes it
    task automatic write_reg(input int ch, input reg_sel_e sel, input cfg_word_u data);
        int waited;
        waited    = 0;
        cfg_valid = 1'b1;
        cfg_ch    = ch[ch_idx_w-1:0];
        cfg_sel   = sel;
        cfg_data  = data;
        while (!cfg_ready && waited < 20) begin
            step();
            waited++;
        end
        if (!cfg_ready) begin
            timeout_fail("cfg_ready never came up for a host write");
        end
        step();                      // Accepted on this edge
        cfg_valid = 1'b0;
    endtask

    // Keep evt_ready high until the event bus has been idle for a few cycles
    task automatic drain_events();
        int idle_cycles;
        int waited;
        idle_cycles = 0;
        waited      = 0;
        evt_ready   = 1'b1;
        while (idle_cycles < 4 && waited < 100) begin
            step();
            waited++;
            idle_cycles = evt_valid ? 0 : idle_cycles + 1;
        end
        if (idle_cycles < 4) begin
            timeout_fail("evt_valid kept coming after mode off");
        end
    endtask

    task automatic run_row(input row_t r);
        for (int ch = 0; ch < num_ch; ch++) begin
            if (r.mask[ch]) begin
                write_reg(ch, reg_reload, raw_word(r.reload));
                write_reg(ch, reg_compare, raw_word(r.compare));
            end
        end
        checker_i.begin_test(r.name, r.mask, r.mode, r.presc, r.reload, r.compare,
                             r.run, r.bp);
        // Channel 0 starts last, after a stall it has to wait for its turn
        for (int k = 1; k <= num_ch; k++) begin
            if (r.mask[k % num_ch]) begin
                write_reg(k % num_ch, reg_ctrl, ctrl_word(1'b1, r.mode, r.presc));
            end
        end
        for (int i = 0; i < r.run; i++) begin
            if (r.bp && i >= 40 && i < 80) begin
                evt_ready = 1'b0;    // Long stall, the channel must overrun
            end else if (r.bp) begin
                evt_ready = ($urandom % 2) != 0;
            end else if ($countones(r.mask) > 1 && i >= 4 && i < 10) begin
                evt_ready = 1'b0;    // Short stall, all channels request at once
            end else begin
                evt_ready = 1'b1;
            end
            step();
        end
        for (int k = 1; k <= num_ch; k++) begin
            if (r.mask[k % num_ch]) begin
                write_reg(k % num_ch, reg_ctrl, ctrl_word(1'b0, mode_off, 0));
            end
        end
        drain_events();
        checker_i.finish_test();     // Counts, then the quiet window starts
        repeat (16) step();
        checker_i.end_quiet();
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cfg_valid = 1'b0;
        cfg_ch    = '0;
        cfg_sel   = reg_ctrl;
        cfg_data  = '0;
        evt_ready = 1'b1;
        void'($urandom(32'ha536));   // Seeds the stall pattern
        repeat (16) step();
        if (cfg_ready !== 1'b0) begin
            $display("Mismatch reset: cfg_ready expected 0 actual %0d", cfg_ready);
            bench_errors++;
        end
        rst_n = 1'b1;
        foreach (rows[i]) begin
            if (!timed_out) begin
                run_row(rows[i]);
            end
        end
        $display("Checker errors %0d, assertion failures %0d, bench errors %0d",
                 checker_i.errors, timer_subsystem_i.event_arbiter_i.timer_assert_i.fail_cnt,
                 bench_errors);
        if (checker_i.errors == 0 && bench_errors == 0 &&
            timer_subsystem_i.event_arbiter_i.timer_assert_i.fail_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* sources.f */
design/timer_pkg.sv
design/evt_pkg.sv
design/timer_regs.sv
design/multi_mode_timer.sv
design/event_arbiter.sv
design/timer_subsystem.sv
bench/timer_assert.sv
bench/timer_checker.sv
bench/tb_timer_subsystem.sv

/* Bender.yml */
package:
  name: timer_subsystem

sources:
  # Packages first, the RTL imports them
  - design/timer_pkg.sv
  - design/evt_pkg.sv
  - design/timer_regs.sv
  - design/multi_mode_timer.sv
  - design/event_arbiter.sv
  - design/timer_subsystem.sv

  - target: test
    files:
      - bench/timer_assert.sv
      - bench/timer_checker.sv
      - bench/tb_timer_subsystem.sv
